// ==== design/cpu_pkg.sv ====
// Accumulator CPU shared definitions
package cpu_pkg;

  typedef logic [31:0] word_t;  // Data, address and instruction word

  typedef enum logic [3:0] {
    op_ldi  = 4'h0,  // Acc = sign-extended 28-bit immediate
    op_ld   = 4'h1,
    op_st   = 4'h2,
    op_add  = 4'h3,
    op_sub  = 4'h4,
    op_and  = 4'h5,
    op_xor  = 4'h6,
    op_jmp  = 4'h7,
    op_jz   = 4'h8,  // Taken when the last acc write was zero
    op_in   = 4'h9,  // Acc = zero-extended ui_in
    op_halt = 4'hf
  } opcode_e;

  typedef enum logic [3:0] {
    alu_pass = 4'h0,  // Result is operand b
    alu_add  = 4'h1,
    alu_sub  = 4'h2,
    alu_and  = 4'h3,
    alu_xor  = 4'h4
  } alu_op_e;

  // Data instructions carry a memory address or an immediate
  typedef struct packed {
    opcode_e     opcode;
    logic [27:0] operand;
  } insn_alu_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [3:0]  reserved;
    logic [23:0] target;  // Word address of the jump
  } insn_jump_t;

  typedef union packed {
    insn_alu_t  alu_view;
    insn_jump_t jump_view;
  } insn_u;

  typedef struct packed {
    word_t addr;   // Word address
    word_t wdata;
    logic  write;
  } bus_req_t;

  typedef struct packed {
    word_t rdata;
  } bus_rsp_t;

  // Pin frame layout
  localparam int cmd_start_bit    = 7;
  localparam int cmd_write_bit    = 0;
  localparam int frame_addr_bytes = 4;
  localparam int frame_read_bytes = 4;

endpackage

// ==== design/acc_alu.sv ====
// Accumulator ALU
`timescale 1ns/1ps

module acc_alu (
  input  cpu_pkg::alu_op_e op,
  input  cpu_pkg::word_t   a,     // Accumulator
  input  cpu_pkg::word_t   b,     // Memory operand or immediate
  output cpu_pkg::word_t   y,
  output logic             zero
);

  always_comb begin
    case (op)
      cpu_pkg::alu_add: begin
        y = a + b;
      end
      cpu_pkg::alu_sub: begin
        y = a - b;
      end
      cpu_pkg::alu_and: begin
        y = a & b;
      end
      cpu_pkg::alu_xor: begin
        y = a ^ b;
      end
      default: begin
        y = b;  // Pass for loads, immediates and pin reads
      end
    endcase
  end

  assign zero = (y == 32'h0);  // Latched by the CPU for JZ

endmodule

// ==== design/accum_cpu.sv ====
// Accumulator CPU sequencer
`timescale 1ns/1ps

module accum_cpu (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [7:0]        in_pins,
  output logic              req_valid,
  output cpu_pkg::bus_req_t req,
  input  logic              rsp_valid,
  input  cpu_pkg::bus_rsp_t rsp
);

  typedef enum logic [2:0] {
    st_fetch,         // First fetch after reset
    st_fetch_wait,
    st_execute,
    st_operand_wait,
    st_store_wait,
    st_halted
  } state_e;

  state_e           state;
  cpu_pkg::word_t   pc;
  cpu_pkg::word_t   acc;
  logic             zero_q;
  cpu_pkg::insn_u   ir;

  cpu_pkg::opcode_e opcode;
  cpu_pkg::word_t   imm_ext;
  cpu_pkg::word_t   operand_addr;
  cpu_pkg::word_t   jump_addr;
  cpu_pkg::word_t   pc_inc;
  cpu_pkg::word_t   next_pc;
  cpu_pkg::alu_op_e alu_op;
  cpu_pkg::word_t   alu_b;
  cpu_pkg::word_t   alu_y;
  logic             alu_zero;

  function automatic cpu_pkg::bus_req_t make_req(input cpu_pkg::word_t addr,
                                                 input cpu_pkg::word_t wdata,
                                                 input logic           write);
    cpu_pkg::bus_req_t r;
    r.addr  = addr;
    r.wdata = wdata;
    r.write = write;
    return r;
  endfunction

  // Both views share the opcode field
  assign opcode       = ir.alu_view.opcode;
  assign imm_ext      = {{4{ir.alu_view.operand[27]}}, ir.alu_view.operand};
  assign operand_addr = {4'h0, ir.alu_view.operand};
  assign jump_addr    = {8'h00, ir.jump_view.target};
  assign pc_inc       = pc + 32'd1;  // One word per instruction

  always_comb begin
    case (opcode)
      cpu_pkg::op_jmp: next_pc = jump_addr;
      cpu_pkg::op_jz:  next_pc = zero_q ? jump_addr : pc_inc;
      default:         next_pc = pc_inc;
    endcase
  end

  always_comb begin
    case (opcode)
      cpu_pkg::op_add: alu_op = cpu_pkg::alu_add;
      cpu_pkg::op_sub: alu_op = cpu_pkg::alu_sub;
      cpu_pkg::op_and: alu_op = cpu_pkg::alu_and;
      cpu_pkg::op_xor: alu_op = cpu_pkg::alu_xor;
      default:         alu_op = cpu_pkg::alu_pass;
    endcase
  end

  // Operand comes from the bus, the pins or the immediate field
  always_comb begin
    if (state == st_operand_wait) begin
      alu_b = rsp.rdata;
    end else if (opcode == cpu_pkg::op_in) begin
      alu_b = {24'h0, in_pins};
    end else begin
      alu_b = imm_ext;
    end
  end

  acc_alu alu_i (
    .op   (alu_op),
    .a    (acc),
    .b    (alu_b),
    .y    (alu_y),
    .zero (alu_zero)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_fetch;
      pc        <= 32'h0;
      acc       <= 32'h0;
      zero_q    <= 1'b1;  // Matches acc of zero
      req_valid <= 1'b0;
    end else begin
      req_valid <= 1'b0;
      case (state)
        st_fetch: begin
          req_valid <= 1'b1;
          req       <= make_req(pc, 32'h0, 1'b0);
          state     <= st_fetch_wait;
        end
        st_fetch_wait: begin
          if (rsp_valid) begin
            ir    <= cpu_pkg::insn_u'(rsp.rdata);
            state <= st_execute;
          end
        end
        st_execute: begin
          case (opcode)
            cpu_pkg::op_ld, cpu_pkg::op_add, cpu_pkg::op_sub,
            cpu_pkg::op_and, cpu_pkg::op_xor: begin
              req_valid <= 1'b1;
              req       <= make_req(operand_addr, 32'h0, 1'b0);
              state     <= st_operand_wait;
            end
            cpu_pkg::op_st: begin
              req_valid <= 1'b1;
              req       <= make_req(operand_addr, acc, 1'b1);
              state     <= st_store_wait;
            end
            cpu_pkg::op_halt: begin
              state <= st_halted;  // No more bus traffic
            end
            default: begin
              if (opcode == cpu_pkg::op_ldi || opcode == cpu_pkg::op_in) begin
                acc    <= alu_y;
                zero_q <= alu_zero;
              end
              pc        <= next_pc;
              req_valid <= 1'b1;
              req       <= make_req(next_pc, 32'h0, 1'b0);
              state     <= st_fetch_wait;
            end
          endcase
        end
        st_operand_wait: begin
          if (rsp_valid) begin
            acc       <= alu_y;
            zero_q    <= alu_zero;
            pc        <= pc_inc;
            req_valid <= 1'b1;
            req       <= make_req(pc_inc, 32'h0, 1'b0);
            state     <= st_fetch_wait;
          end
        end
        st_store_wait: begin
          if (rsp_valid) begin  // Write completion only
            pc        <= pc_inc;
            req_valid <= 1'b1;
            req       <= make_req(pc_inc, 32'h0, 1'b0);
            state     <= st_fetch_wait;
          end
        end
        default: begin
          state <= st_halted;
        end
      endcase
    end
  end

endmodule

// ==== design/pin_bus_serializer.sv ====
// Bus to pin frame serializer
`timescale 1ns/1ps

module pin_bus_serializer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid,
  input  cpu_pkg::bus_req_t req,
  output logic              rsp_valid,
  output cpu_pkg::bus_rsp_t rsp,
  output logic [7:0]        uo_out,
  output logic [7:0]        uio_out,
  output logic [7:0]        uio_oe,
  input  logic [7:0]        uio_in
);

  logic           active;
  logic [3:0]     phase;       // 0 command, 1-4 address, 5-8 read data
  logic           write_q;
  cpu_pkg::word_t addr_sh;
  cpu_pkg::word_t wdata_sh;
  cpu_pkg::word_t rdata_q;
  logic [7:0]     cmd_byte;
  logic           cmd_phase;
  logic           addr_phase;
  logic           read_phase;
  logic [3:0]     last_phase;

  assign cmd_phase  = active && (phase == 4'd0);
  assign addr_phase = active && (phase != 4'd0) &&
                      (phase <= 4'(cpu_pkg::frame_addr_bytes));
  assign read_phase = active && (phase > 4'(cpu_pkg::frame_addr_bytes));

  // Writes end after the address bytes
  assign last_phase = write_q ? 4'(cpu_pkg::frame_addr_bytes) :
                      4'(cpu_pkg::frame_addr_bytes + cpu_pkg::frame_read_bytes);

  always_comb begin
    cmd_byte                         = 8'h00;
    cmd_byte[cpu_pkg::cmd_start_bit] = 1'b1;
    cmd_byte[cpu_pkg::cmd_write_bit] = write_q;
  end

  always_comb begin
    uo_out  = 8'h00;
    uio_out = 8'h00;
    uio_oe  = 8'h00;
    if (cmd_phase) begin
      uo_out = cmd_byte;
    end else if (addr_phase) begin
      uo_out = addr_sh[7:0];  // LSB first
      if (write_q) begin
        uio_out = wdata_sh[7:0];
        uio_oe  = 8'hff;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active    <= 1'b0;
      phase     <= 4'd0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      if (active) begin
        if (phase == last_phase) begin
          active    <= 1'b0;
          rsp_valid <= 1'b1;
        end
        phase <= phase + 4'd1;
      end else if (req_valid) begin
        active <= 1'b1;
        phase  <= 4'd0;
      end
    end
  end

  // Request payload and byte shifters
  always_ff @(posedge clk) begin
    if (!active && req_valid) begin
      write_q  <= req.write;
      addr_sh  <= req.addr;
      wdata_sh <= req.wdata;
    end else if (addr_phase) begin
      addr_sh  <= addr_sh >> 8;
      wdata_sh <= wdata_sh >> 8;
    end
    if (read_phase) begin
      rdata_q <= {uio_in, rdata_q[31:8]};  // First byte ends up lowest
    end
  end

  assign rsp.rdata = rdata_q;

endmodule

// ==== design/tt_um_cpuhandler.sv ====
// Tiny Tapeout CPU top
`timescale 1ns/1ps

module tt_um_cpuhandler (
  input  wire [7:0] ui_in,    // Read by the IN instruction
  output wire [7:0] uo_out,   // Command and address bytes
  input  wire [7:0] uio_in,   // Read data bytes
  output wire [7:0] uio_out,  // Write data bytes
  output wire [7:0] uio_oe,
  input  wire       ena,      // Always high on the chip, not needed here
  input  wire       clk,
  input  wire       rst_n
);

  logic              req_valid;
  cpu_pkg::bus_req_t req;
  logic              rsp_valid;
  cpu_pkg::bus_rsp_t rsp;

  accum_cpu cpu_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_pins   (ui_in),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  pin_bus_serializer ser_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .uo_out    (uo_out),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe),
    .uio_in    (uio_in)
  );

endmodule

// ==== tb/ext_memory_model.sv ====
// External frame memory model
`timescale 1ns/1ps

module ext_memory_model (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] uo_out,
  input  logic [7:0] uio_out,
  input  logic [7:0] uio_oe,
  output logic [7:0] uio_in,
  output logic       busy      // Inside a frame, past its command byte
);

  typedef enum logic [1:0] {
    ms_idle,
    ms_addr,
    ms_data
  } mem_state_e;

  logic [31:0] mem [0:255];    // Preloaded by tb_top
  logic [31:0] log_addr [0:63];
  logic [31:0] log_data [0:63];
  int          log_count;
  int          frames;
  int          reads;
  logic [31:0] first_read_addr;

  mem_state_e  state;
  logic [1:0]  cnt;
  logic        wr;
  logic [31:0] addr_q;
  logic [31:0] data_q;
  logic [31:0] rd_word;

  assign busy   = (state != ms_idle);
  assign uio_in = (state == ms_data) ? rd_word[8*cnt +: 8] : 8'h00;  // LSB first

  always @(posedge clk) begin : frame_fsm
    logic [31:0] a;
    logic [31:0] d;
    if (!rst_n) begin
      state     <= ms_idle;
      cnt       <= 2'd0;
      log_count <= 0;
      frames    <= 0;
      reads     <= 0;
    end else begin
      case (state)
        ms_idle: begin
          if (uo_out[7]) begin  // Command byte starts a frame
            state  <= ms_addr;
            cnt    <= 2'd0;
            wr     <= uo_out[0];
            frames <= frames + 1;
          end
        end
        ms_addr: begin
          a      = {uo_out, addr_q[31:8]};
          d      = {(uio_oe == 8'hff) ? uio_out : 8'h00, data_q[31:8]};
          addr_q <= a;
          data_q <= d;
          cnt    <= cnt + 2'd1;
          if (cnt == 2'd3) begin
            cnt <= 2'd0;
            if (wr) begin
              mem[a[7:0]]         <= d;
              log_addr[log_count] <= a;
              log_data[log_count] <= d;
              log_count           <= log_count + 1;
              state               <= ms_idle;
            end else begin
              rd_word <= mem[a[7:0]];
              if (reads == 0) begin
                first_read_addr <= a;
              end
              reads <= reads + 1;
              state <= ms_data;
            end
          end
        end
        default: begin
          cnt <= cnt + 2'd1;
          if (cnt == 2'd3) begin
            state <= ms_idle;
          end
        end
      endcase
    end
  end

endmodule

// ==== tb/tb_top.sv ====
// CPU handler testbench
`timescale 1ns/1ps

module tb_top;

  localparam int max_cycles = 4000;
  localparam logic [7:0] pin_value = 8'ha5;

  logic       clk;
  logic       rst_n;
  logic [7:0] ui_in;
  logic [7:0] uo_out;
  logic [7:0] uio_in;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;
  logic       ena;
  logic       mem_busy;
  logic       started;
  logic       cmd_cyc;
  int         errors;
  int         cycles;
  int         seed;
  int         frames_at_halt;

  logic [31:0] ref_mem [0:255];
  logic [31:0] exp_addr [0:63];
  logic [31:0] exp_data [0:63];
  int          exp_count;
  int          exp_frames;

  tt_um_cpuhandler dut_i (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  ext_memory_model mem_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .uio_in  (uio_in),
    .busy    (mem_busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
  end

  initial begin
    wait (cycles >= max_cycles);
    $display("timeout: program did not finish within %0d cycles", max_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  assign cmd_cyc = started && !mem_busy && uo_out[7];

  // Pins stay quiet outside frames
  a_idle: assert property (@(posedge clk) disable iff (!started)
    (!mem_busy && !uo_out[7]) |->
      (uo_out == 8'h00 && uio_out == 8'h00 && uio_oe == 8'h00))
    else begin
      errors++;
      $display("error at %0t: pins not idle outside a frame", $time);
    end

  a_cmd: assert property (@(posedge clk) cmd_cyc |-> (uo_out[6:1] == 6'h0 && uio_oe == 8'h00))
    else begin
      errors++;
      $display("error at %0t: bad command byte %h", $time, uo_out);
    end

  a_write_frame: assert property (@(posedge clk) (cmd_cyc && uo_out[0]) |=>
    uio_oe == 8'hff ##1 uio_oe == 8'hff ##1 uio_oe == 8'hff ##1 uio_oe == 8'hff
    ##1 (uio_oe == 8'h00 && uo_out == 8'h00))
    else begin
      errors++;
      $display("error at %0t: write frame has wrong uio_oe", $time);
    end

  a_read_frame: assert property (@(posedge clk) (cmd_cyc && !uo_out[0]) |=>
    uio_oe == 8'h00 ##1 uio_oe == 8'h00 ##1 uio_oe == 8'h00 ##1 uio_oe == 8'h00
    ##1 (uo_out == 8'h00 && uio_oe == 8'h00) [*5])
    else begin
      errors++;
      $display("error at %0t: read frame has wrong pins", $time);
    end

  function automatic logic [31:0] enc(input cpu_pkg::opcode_e op, input logic [27:0] operand);
    return {op, operand};
  endfunction

  task automatic load_program();
    int i;
    for (i = 0; i < 256; i++) begin
      mem_i.mem[i] = $random(seed);
    end
    mem_i.mem[0]  = enc(cpu_pkg::op_ldi, 28'd5);
    mem_i.mem[1]  = enc(cpu_pkg::op_st, 28'h60);
    mem_i.mem[2]  = enc(cpu_pkg::op_ld, 28'h40);
    mem_i.mem[3]  = enc(cpu_pkg::op_st, 28'h61);
    mem_i.mem[4]  = enc(cpu_pkg::op_add, 28'h41);
    mem_i.mem[5]  = enc(cpu_pkg::op_st, 28'h62);
    mem_i.mem[6]  = enc(cpu_pkg::op_sub, 28'h42);
    mem_i.mem[7]  = enc(cpu_pkg::op_st, 28'h63);
    mem_i.mem[8]  = enc(cpu_pkg::op_and, 28'h43);
    mem_i.mem[9]  = enc(cpu_pkg::op_st, 28'h64);
    mem_i.mem[10] = enc(cpu_pkg::op_xor, 28'h44);
    mem_i.mem[11] = enc(cpu_pkg::op_st, 28'h65);
    mem_i.mem[12] = enc(cpu_pkg::op_in, 28'h0);
    mem_i.mem[13] = enc(cpu_pkg::op_st, 28'h66);
    mem_i.mem[14] = enc(cpu_pkg::op_ldi, 28'd3);   // Loop counter
    mem_i.mem[15] = enc(cpu_pkg::op_st, 28'h67);   // Loop top
    mem_i.mem[16] = enc(cpu_pkg::op_sub, 28'h50);
    mem_i.mem[17] = {cpu_pkg::op_jz, 4'h0, 24'd19};
    mem_i.mem[18] = {cpu_pkg::op_jmp, 4'h0, 24'd15};
    mem_i.mem[19] = enc(cpu_pkg::op_st, 28'h68);
    mem_i.mem[20] = enc(cpu_pkg::op_ldi, 28'hffffff9);  // Minus seven
    mem_i.mem[21] = enc(cpu_pkg::op_st, 28'h69);
    mem_i.mem[22] = enc(cpu_pkg::op_halt, 28'h0);
    mem_i.mem[8'h50] = 32'd1;  // Loop decrement
    for (i = 0; i < 256; i++) begin
      ref_mem[i] = mem_i.mem[i];
    end
  endtask

  // Interprets the program by the opcode rules and counts bus frames
  task automatic run_reference();
    int          n;
    logic [31:0] pc;
    logic [31:0] acc;
    logic [31:0] w;
    logic [31:0] opnd;
    logic        z;
    logic        done;
    pc = 0;
    acc = 0;
    z = 1'b1;
    done = 1'b0;
    exp_count = 0;
    exp_frames = 0;
    for (n = 0; n < 500 && !done; n++) begin
      w = ref_mem[pc[7:0]];
      opnd = ref_mem[w[7:0]];
      exp_frames++;
      pc = pc + 1;
      case (w[31:28])
        cpu_pkg::op_ldi: acc = {{4{w[27]}}, w[27:0]};
        cpu_pkg::op_ld:  acc = opnd;
        cpu_pkg::op_add: acc = acc + opnd;
        cpu_pkg::op_sub: acc = acc - opnd;
        cpu_pkg::op_and: acc = acc & opnd;
        cpu_pkg::op_xor: acc = acc ^ opnd;
        cpu_pkg::op_in:  acc = {24'h0, pin_value};
        cpu_pkg::op_st: begin
          ref_mem[w[7:0]] = acc;
          exp_addr[exp_count] = {4'h0, w[27:0]};
          exp_data[exp_count] = acc;
          exp_count++;
        end
        cpu_pkg::op_jmp: pc = {8'h0, w[23:0]};
        cpu_pkg::op_jz: begin
          if (z) begin
            pc = {8'h0, w[23:0]};
          end
        end
        default: done = 1'b1;  // Halt
      endcase
      if (w[31:28] inside {cpu_pkg::op_ld, cpu_pkg::op_add, cpu_pkg::op_sub,
                           cpu_pkg::op_and, cpu_pkg::op_xor, cpu_pkg::op_st}) begin
        exp_frames++;  // Operand read or store
      end
      if (w[31:28] inside {cpu_pkg::op_ldi, cpu_pkg::op_ld, cpu_pkg::op_add, cpu_pkg::op_sub,
                           cpu_pkg::op_and, cpu_pkg::op_xor, cpu_pkg::op_in}) begin
        z = (acc == 32'h0);
      end
    end
  endtask

  initial begin
    int i;
    seed = 32'h12b8;
    errors = 0;
    cycles = 0;
    started = 1'b0;
    rst_n = 1'b0;
    ui_in = 8'h00;
    ena = 1'b1;
    load_program();
    run_reference();
    repeat (2) @(posedge clk);
    #1;
    started = 1'b1;
    ui_in = pin_value;  // Set before the program runs
    repeat (14) @(posedge clk);
    #1;
    rst_n = 1'b1;
    while (mem_i.frames < exp_frames) begin
      @(posedge clk);
    end
    frames_at_halt = mem_i.frames;
    repeat (200) @(posedge clk);
    assert (mem_i.frames == frames_at_halt)
      else begin
        errors++;
        $display("error at %0t: frame started after halt", $time);
      end
    assert (mem_i.first_read_addr == 32'h0)
      else begin
        errors++;
        $display("error at %0t: first fetch not at address 0", $time);
      end
    assert (mem_i.log_count == exp_count)
      else begin
        errors++;
        $display("error at %0t: %0d writes, expected %0d", $time, mem_i.log_count, exp_count);
      end
    for (i = 0; i < exp_count && i < mem_i.log_count; i++) begin
      assert (mem_i.log_addr[i] == exp_addr[i] && mem_i.log_data[i] == exp_data[i])
        else begin
          errors++;
          $display("error at %0t: write %0d got %h <= %h, expected %h <= %h", $time, i,
                   mem_i.log_addr[i], mem_i.log_data[i], exp_addr[i], exp_data[i]);
        end
    end
    $display("checked %0d writes and %0d frames, %0d errors", exp_count, exp_frames, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
design/cpu_pkg.sv
design/acc_alu.sv
design/accum_cpu.sv
design/pin_bus_serializer.sv
design/tt_um_cpuhandler.sv
tb/ext_memory_model.sv
tb/tb_top.sv

// ==== Bender.yml ====
package:
  name: cpuhandler

sources:
  - design/cpu_pkg.sv
  - design/acc_alu.sv
  - design/accum_cpu.sv
  - design/pin_bus_serializer.sv
  - design/tt_um_cpuhandler.sv
  - target: simulation
    files:
      - tb/ext_memory_model.sv
      - tb/tb_top.sv
